/* flist.f */
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/fetch_stage.sv
rtl/ctrl.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_core.sv
tests/tb_rv_core.sv

/* rtl/ctrl.sv */
`default_nettype none

module ctrl (
    input  rv_isa_pkg::inst_u   inst,
    output rv_pipe_pkg::ctrl_t  ctrl
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic bad;

    always_comb begin
        ctrl = '0;
        bad  = 1'b0;
        case (inst.r.opcode)
            op_r_type: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = inst.r.rd;
                ctrl.reg1_raddr = inst.r.rs1;
                ctrl.reg2_raddr = inst.r.rs2;
                ctrl.alu_src    = src_reg;
                if (inst.r.funct3 != funct3_add_sub) begin
                    bad = 1'b1;
                end else if (inst.r.funct7 == funct7_add) begin
                    ctrl.alu_op = alu_add;
                end else if (inst.r.funct7 == funct7_sub) begin
                    ctrl.alu_op = alu_sub;
                end else begin
                    bad = 1'b1;
                end
            end
            op_i_type: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = inst.i.rd;
                ctrl.reg1_raddr = inst.i.rs1;
                ctrl.imm_op     = imm_i;
                ctrl.alu_op     = alu_add;
                ctrl.alu_src    = src_imm;
                if (inst.i.funct3 != funct3_addi) begin
                    bad = 1'b1; // only addi
                end
            end
            op_b_type: begin
                ctrl.reg1_raddr = inst.b.rs1;
                ctrl.reg2_raddr = inst.b.rs2;
                ctrl.imm_op     = imm_b;
                ctrl.alu_op     = alu_sub; // nonzero diff means taken
                ctrl.alu_src    = src_reg;
                if (inst.b.funct3 == funct3_bne) begin
                    ctrl.branch = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            op_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = inst.j.rd;
                ctrl.imm_op    = imm_j;
                ctrl.alu_op    = alu_add;
                ctrl.alu_src   = src_four_pc; // link value
            end
            op_lui: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = inst.u.rd;
                ctrl.reg1_raddr = '0; // x0 + imm
                ctrl.imm_op     = imm_u;
                ctrl.alu_op     = alu_add;
                ctrl.alu_src    = src_imm;
            end
            op_system: begin
                ctrl.ebreak = 1'b1;
            end
            default: begin
                bad = 1'b1;
            end
        endcase

        // An unknown word must not write or branch, only flag itself.
        if (bad) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  rv_pipe_pkg::fd_t                  fd,
    input  logic                              stop,
    input  logic                              squash,
    output logic [rv_isa_pkg::reg_addr_w-1:0] raddr1,
    output logic [rv_isa_pkg::reg_addr_w-1:0] raddr2,
    input  logic [rv_isa_pkg::xlen-1:0]       rdata1,
    input  logic [rv_isa_pkg::xlen-1:0]       rdata2,
    output rv_pipe_pkg::de_t                  de
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    ctrl_t           dec_ctrl;
    logic [xlen-1:0] imm;
    logic            de_valid;
    logic [xlen-1:0] de_pc;
    ctrl_t           de_ctrl;
    logic [xlen-1:0] de_rs1;
    logic [xlen-1:0] de_rs2;
    logic [xlen-1:0] de_imm;

    ctrl u_ctrl (
        .inst (fd.inst),
        .ctrl (dec_ctrl)
    );

    assign raddr1 = dec_ctrl.reg1_raddr;
    assign raddr2 = dec_ctrl.reg2_raddr;

    always_comb begin
        case (dec_ctrl.imm_op)
            imm_i: imm = {{20{fd.inst.i.imm_11_0[11]}}, fd.inst.i.imm_11_0};
            imm_b: imm = {{19{fd.inst.b.imm_12}}, fd.inst.b.imm_12, fd.inst.b.imm_11,
                          fd.inst.b.imm_10_5, fd.inst.b.imm_4_1, 1'b0};
            imm_j: imm = {{11{fd.inst.j.imm_20}}, fd.inst.j.imm_20, fd.inst.j.imm_19_12,
                          fd.inst.j.imm_11, fd.inst.j.imm_10_1, 1'b0};
            default: imm = {fd.inst.u.imm_31_12, 12'b0}; // imm_u
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= fd.valid && !squash && !stop;
        end
    end

    always_ff @(posedge clk) begin
        de_pc   <= fd.pc;
        de_ctrl <= dec_ctrl;
        de_rs1  <= rdata1;
        de_rs2  <= rdata2;
        de_imm  <= imm;
    end

    assign de = '{valid: de_valid, pc: de_pc, ctrl: de_ctrl,
                  rs1_val: de_rs1, rs2_val: de_rs2, imm: de_imm};

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  rv_pipe_pkg::de_t                  de,
    output logic                              wen,
    output logic [rv_isa_pkg::reg_addr_w-1:0] waddr,
    output logic [rv_isa_pkg::xlen-1:0]       wdata,
    output logic                              redirect,
    output logic [rv_isa_pkg::xlen-1:0]       redirect_pc,
    output logic                              stop,
    output logic                              retire_valid,
    output rv_pipe_pkg::retire_t              retire,
    output logic                              halted,
    output logic                              illegal
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;
    logic            halt_now;
    logic            exec_ok;

    assign op_a = (de.ctrl.alu_src == src_four_pc) ? de.pc : de.rs1_val;

    always_comb begin
        case (de.ctrl.alu_src)
            src_reg:     op_b = de.rs2_val;
            src_imm:     op_b = de.imm;
            src_four_pc: op_b = xlen'(4);
            default:     op_b = de.rs2_val;
        endcase
    end

    assign result = (de.ctrl.alu_op == alu_sub) ? op_a - op_b : op_a + op_b;

    assign halt_now = de.valid && (de.ctrl.ebreak || de.ctrl.illegal);
    assign exec_ok  = de.valid && !halt_now;

    assign redirect    = exec_ok && (de.ctrl.jump || (de.ctrl.branch && (result != '0)));
    assign redirect_pc = de.pc + de.imm;

    assign wen   = exec_ok && de.ctrl.reg_wen;
    assign waddr = de.ctrl.reg_waddr;
    assign wdata = result;

    assign stop = halted || halt_now;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire_valid <= exec_ok;
            halted       <= halted || halt_now;
            illegal      <= illegal || (de.valid && de.ctrl.illegal); // sticky
        end
    end

    always_ff @(posedge clk) begin
        retire.pc    <= de.pc;
        retire.rd    <= de.ctrl.reg_waddr;
        retire.wdata <= de.ctrl.reg_wen ? result : '0; // bne reports no data
    end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               run,
    input  logic                               stop,
    input  logic                               redirect,
    input  logic [rv_isa_pkg::xlen-1:0]        redirect_pc,
    input  logic                               imem_we,
    input  logic [rv_pipe_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [rv_isa_pkg::xlen-1:0]        imem_wdata,
    output rv_pipe_pkg::fd_t                   fd
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [xlen-1:0]        imem [imem_depth];
    logic [xlen-1:0]        pc;
    logic                   fd_valid;
    logic [xlen-1:0]        fd_pc;
    logic [xlen-1:0]        fd_inst;
    logic [imem_addr_w-1:0] pc_word;

    assign pc_word = pc[imem_addr_w+1:2]; // wraps at imem_depth

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else if (stop) begin
            fd_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fd_valid <= 1'b0; // wrong-path slot
        end else if (run) begin
            pc       <= pc + xlen'(4);
            fd_valid <= 1'b1;
        end else begin
            fd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        fd_pc   <= pc;
        fd_inst <= imem[pc_word];
    end

    assign fd = '{valid: fd_valid, pc: fd_pc, inst: fd_inst};

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_isa_pkg::xlen-1:0]       rdata1,
    output logic [rv_isa_pkg::xlen-1:0]       rdata2,
    input  logic                              wen,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_isa_pkg::xlen-1:0]       wdata
);

    import rv_isa_pkg::*;

    logic [xlen-1:0] regs [1:31];

    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wen && (waddr == addr)) begin
            return wdata; // write-first bypass
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`default_nettype none

module rv_core (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                imem_we,
    input  logic [rv_pipe_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [rv_isa_pkg::xlen-1:0]         imem_wdata,
    input  logic                                run,
    output logic                                retire_valid,
    output rv_pipe_pkg::retire_t                retire,
    output logic                                halted,
    output logic                                illegal
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    fd_t                   fd;
    de_t                   de;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic                  wen;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
    logic                  redirect;
    logic [xlen-1:0]       redirect_pc;
    logic                  stop;

    fetch_stage u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .stop        (stop),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .fd          (fd)
    );

    decode_stage u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .fd     (fd),
        .stop   (stop),
        .squash (redirect),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .de     (de)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    execute_stage u_execute (
        .clk          (clk),
        .arst_n       (arst_n),
        .de           (de),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .stop         (stop),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes of the supported subset
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_i_type = 7'b0010011;
    localparam logic [6:0] op_b_type = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_addi    = 3'b000;
    localparam logic [2:0] funct3_bne     = 3'b001;

    localparam logic [6:0] funct7_add = 7'b0000000;
    localparam logic [6:0] funct7_sub = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } inst_b_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_j_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_u_t;

    // one instruction word, five views
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_b_t b;
        inst_j_t j;
        inst_u_t u;
    } inst_u;

endpackage

`default_nettype wire

/* rtl/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    localparam int imem_depth  = 64;
    localparam int imem_addr_w = 6;

    typedef enum logic {
        alu_add,
        alu_sub
    } alu_op_e;

    typedef enum logic [1:0] {
        src_reg,
        src_imm,
        src_four_pc
    } alu_src_e;

    typedef enum logic [1:0] {
        imm_i,
        imm_b,
        imm_j,
        imm_u
    } imm_op_e;

    typedef struct packed {
        logic                  branch;
        logic                  jump;
        logic                  reg_wen;
        logic [reg_addr_w-1:0] reg_waddr;
        logic [reg_addr_w-1:0] reg1_raddr;
        logic [reg_addr_w-1:0] reg2_raddr;
        imm_op_e               imm_op;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic                  ebreak;
        logic                  illegal;
    } ctrl_t;

    // fetch/decode register
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        inst_u           inst;
    } fd_t;

    // decode/execute register
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        ctrl_t           ctrl;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
    } de_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
    } retire_t;

endpackage

`default_nettype wire

/* tests/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int drive_delay = 5; // after the rising edge
    localparam int halt_limit  = 400;

    logic                   clk;
    logic                   arst_n;
    logic                   imem_we;
    logic [imem_addr_w-1:0] imem_addr;
    logic [xlen-1:0]        imem_wdata;
    logic                   run;
    logic                   retire_valid;
    retire_t                retire;
    logic                   halted;
    logic                   illegal;

    logic [xlen-1:0] prog [$];
    retire_t         expq [$]; // expected retire records, oldest first
    retire_t         front;
    string           test_name;
    logic            failed;

    rv_core DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .run          (run),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted),
        .illegal      (illegal)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        failed = 1'b1;
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic logic [xlen-1:0] r_word(input logic [6:0] f7, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [xlen-1:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [xlen-1:0] bne_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                                 input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [xlen-1:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [xlen-1:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // sequential ISA model, fills expq
    task automatic run_model(output logic exp_illegal);
        logic [xlen-1:0] regs [32];
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic            wr;
        logic            done;
        retire_t         rec;
        int              steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        expq.delete();
        pc          = '0;
        done        = 1'b0;
        exp_illegal = 1'b0;
        steps       = 0;
        while (!done) begin
            if ((pc >> 2) >= prog.size() || steps > 200) begin
                report_failure($sformatf("%s: reference model ran past the program", test_name));
            end
            w       = prog[pc >> 2];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            next_pc = pc + 4;
            wr      = 1'b1;
            res     = '0;
            case (w[6:0])
                op_r_type: begin
                    if (w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
                        res = a + b;
                    end else if (w[14:12] == 3'b000 && w[31:25] == 7'h20) begin
                        res = a - b;
                    end else begin
                        exp_illegal = 1'b1;
                    end
                end
                op_i_type: begin
                    res = a + {{20{w[31]}}, w[31:20]};
                    exp_illegal = (w[14:12] != 3'b000);
                end
                op_b_type: begin
                    wr = 1'b0;
                    exp_illegal = (w[14:12] != 3'b001);
                    if (a != b) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                op_jal: begin
                    res     = pc + 4;
                    next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                op_lui:    res = {w[31:12], 12'b0};
                op_system: done = 1'b1; // ebreak does not retire
                default:   exp_illegal = 1'b1;
            endcase
            done = done || exp_illegal;
            if (!done) begin
                rec.pc    = pc;
                rec.rd    = wr ? w[11:7] : '0;
                rec.wdata = wr ? res : '0;
                if (wr && w[11:7] != 5'd0) begin
                    regs[w[11:7]] = res;
                end
                expq.push_back(rec);
                pc = next_pc;
            end
            steps++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #drive_delay;
        run    = 1'b0;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;
        assert (retire_valid === 1'b0 && halted === 1'b0 && illegal === 1'b0)
            else report_failure($sformatf("%s: outputs not cleared by reset", test_name));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #drive_delay;
            imem_we    = 1'b1;
            imem_addr  = imem_addr_w'(i);
            imem_wdata = prog[i];
        end
        @(posedge clk);
        #drive_delay;
        imem_we = 1'b0;
    endtask

    task automatic run_test(input string name);
        logic exp_illegal;
        int   cycles;
        test_name = name;
        apply_reset();
        load_program();
        run_model(exp_illegal);
        run    = 1'b1;
        cycles = 0;
        while (halted !== 1'b1) begin
            @(posedge clk);
            #drive_delay;
            cycles++;
            if (cycles > halt_limit) begin
                report_failure($sformatf("%s: core did not halt within %0d cycles",
                                         test_name, halt_limit));
            end
        end
        repeat (4) @(posedge clk); // any late retire would show here
        #drive_delay;
        assert (expq.size() == 0)
            else report_failure($sformatf("%s: %0d expected instructions never retired",
                                          test_name, expq.size()));
        assert (illegal === exp_illegal)
            else report_failure($sformatf("mismatch in %s: illegal expected %0b actual %0b",
                                          test_name, exp_illegal, illegal));
        run = 1'b0;
    endtask

    task automatic build_random(input int n);
        int         kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] last_rd;
        prog.delete();
        last_rd = 5'd1;
        for (int i = 0; i < n; i++) begin
            kind = $urandom_range(0, 9);
            rd   = 5'($urandom_range(1, 7));
            rs1  = (kind < 5) ? last_rd : 5'($urandom_range(0, 7));
            rs2  = (kind[0]) ? last_rd : 5'($urandom_range(0, 7));
            if (kind < 4) begin
                prog.push_back(addi_word(rd, rs1, 12'($urandom)));
            end else if (kind < 6) begin
                prog.push_back(r_word(7'h00, rd, rs1, rs2));
            end else if (kind < 8) begin
                prog.push_back(r_word(7'h20, rd, rs1, rs2));
            end else if (kind == 8 && i < n - 3) begin
                prog.push_back(bne_word(rs1, rs2, 13'(4 * $urandom_range(2, 3)))); // forward
            end else begin
                prog.push_back(addi_word(5'd0, rs1, 12'($urandom)));
            end
            last_rd = rd;
        end
        prog.push_back(32'h0010_0073);
    endtask

    // each retire pulse must match the oldest expected record
    always @(negedge clk) begin
        if (arst_n === 1'b1 && retire_valid !== 1'b0) begin
            assert (expq.size() > 0)
                else report_failure($sformatf("%s: unexpected retire at pc %h",
                                              test_name, retire.pc));
            front = expq.pop_front();
            assert (retire_valid === 1'b1 && retire === front)
                else report_failure($sformatf(
                    "mismatch in %s: expected pc %h rd %0d wdata %h, actual pc %h rd %0d wdata %h",
                    test_name, front.pc, front.rd, front.wdata,
                    retire.pc, retire.rd, retire.wdata));
        end
    end

    initial begin
        void'($urandom(3461));
        clk        = 1'b0;
        arst_n     = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        run        = 1'b0;
        failed     = 1'b0;
        test_name  = "startup";

        for (int t = 0; t < 3; t++) begin
            build_random(24);
            run_test($sformatf("random_alu_%0d", t));
        end

        prog = '{lui_word(5'd1, 20'h12345), jal_word(5'd2, 21'd12),
                 addi_word(5'd3, 5'd0, 12'd1), addi_word(5'd4, 5'd0, 12'd2),
                 r_word(7'h00, 5'd5, 5'd1, 5'd2), jal_word(5'd0, 21'd8),
                 addi_word(5'd6, 5'd0, 12'd3), addi_word(5'd7, 5'd5, 12'hfff),
                 32'h0010_0073};
        run_test("lui_jal");

        prog = '{addi_word(5'd1, 5'd0, 12'd5), addi_word(5'd2, 5'd0, 12'd5),
                 bne_word(5'd1, 5'd2, 13'd8), addi_word(5'd3, 5'd0, 12'd1),
                 addi_word(5'd2, 5'd0, 12'd6), bne_word(5'd1, 5'd2, 13'd12),
                 addi_word(5'd4, 5'd0, 12'd7), addi_word(5'd5, 5'd0, 12'd8),
                 r_word(7'h00, 5'd6, 5'd1, 5'd2), 32'h0010_0073};
        run_test("bne_taken_and_not");

        prog = '{addi_word(5'd1, 5'd0, 12'd9), addi_word(5'd0, 5'd1, 12'd33),
                 r_word(7'h00, 5'd2, 5'd0, 5'd1), r_word(7'h00, 5'd0, 5'd1, 5'd1),
                 r_word(7'h20, 5'd3, 5'd0, 5'd0), addi_word(5'd4, 5'd0, 12'd0),
                 32'h0010_0073};
        run_test("x0_writes");

        prog = '{addi_word(5'd1, 5'd0, 12'd1), 32'h0010_0073,
                 addi_word(5'd2, 5'd0, 12'd2), addi_word(5'd3, 5'd0, 12'd3)};
        run_test("ebreak_halt");

        prog = '{addi_word(5'd1, 5'd0, 12'd3), r_word(7'h00, 5'd2, 5'd1, 5'd1),
                 32'h0000_000b, addi_word(5'd3, 5'd0, 12'd4), 32'h0010_0073};
        run_test("illegal_opcode");

        prog = '{addi_word(5'd1, 5'd0, 12'd3), r_word(7'h01, 5'd2, 5'd1, 5'd1),
                 addi_word(5'd3, 5'd0, 12'd4), 32'h0010_0073};
        run_test("illegal_funct7");

        if (!failed) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
